// ==== hdl/bp_csr.sv ====
`default_nettype none

module bp_csr (
    input  wire logic              clk_i,
    input  wire logic              rst_ni,

    input  wire logic              s_axi_awvalid_i,
    input  wire bp_pkg::csr_addr_t s_axi_awaddr_i,
    input  wire logic              s_axi_wvalid_i,
    input  wire logic [31:0]       s_axi_wdata_i,
    input  wire logic              s_axi_bready_i,
    input  wire logic              s_axi_arvalid_i,
    input  wire bp_pkg::csr_addr_t s_axi_araddr_i,
    input  wire logic              s_axi_rready_i,

    output logic                   s_axi_awready_o,
    output logic                   s_axi_wready_o,
    output logic                   s_axi_bvalid_o,
    output logic [1:0]             s_axi_bresp_o,
    output logic                   s_axi_arready_o,
    output logic                   s_axi_rvalid_o,
    output logic [31:0]            s_axi_rdata_o,
    output logic [1:0]             s_axi_rresp_o,

    bp_ctrl_if.csr                 ctrl
);

    logic         bvalid_q;
    logic         rvalid_q;
    logic [31:0]  rdata_q;
    logic         enable_q;
    bp_pkg::cnt_t upd_cnt_q;
    bp_pkg::cnt_t misp_cnt_q;

    logic         wr_en;
    logic         rd_en;
    logic         clr_upd;
    logic         clr_misp;

    // Clear wins over the count, but an event in the same cycle still counts once
    function automatic bp_pkg::cnt_t next_cnt(bp_pkg::cnt_t cur, logic clr, logic evt);
        bp_pkg::cnt_t nxt;
        if (clr) begin
            nxt = evt ? 32'd1 : 32'd0;
        end else if (evt) begin
            nxt = cur + 32'd1;
        end else begin
            nxt = cur;
        end
        return nxt;
    endfunction

    // Address and data are taken together, one write in flight
    assign wr_en    = s_axi_awvalid_i && s_axi_wvalid_i && !bvalid_q;
    assign rd_en    = s_axi_arvalid_i && !rvalid_q;
    assign clr_upd  = wr_en && (s_axi_awaddr_i == bp_pkg::REG_UPD_CNT);
    assign clr_misp = wr_en && (s_axi_awaddr_i == bp_pkg::REG_MISP_CNT);

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            bvalid_q   <= 1'b0;
            enable_q   <= 1'b1;
            upd_cnt_q  <= '0;
            misp_cnt_q <= '0;
        end else begin
            if (bvalid_q && s_axi_bready_i) begin
                bvalid_q <= 1'b0;
            end else if (wr_en) begin
                bvalid_q <= 1'b1;
            end
            if (wr_en && (s_axi_awaddr_i == bp_pkg::REG_CTRL)) begin
                enable_q <= s_axi_wdata_i[0];
            end
            upd_cnt_q  <= next_cnt(upd_cnt_q, clr_upd, ctrl.upd_evt);
            misp_cnt_q <= next_cnt(misp_cnt_q, clr_misp, ctrl.misp_evt);
        end
    end

    // Read response handshake
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            rvalid_q <= 1'b0;
        end else if (rvalid_q && s_axi_rready_i) begin
            rvalid_q <= 1'b0;
        end else if (rd_en) begin
            rvalid_q <= 1'b1;
        end
    end

    // Read data captured with the address
    always_ff @(posedge clk_i) begin
        if (rd_en) begin
            case (s_axi_araddr_i)
                bp_pkg::REG_CTRL:     rdata_q <= {31'd0, enable_q};
                bp_pkg::REG_GHR:      rdata_q <= 32'(ctrl.ghr);
                bp_pkg::REG_UPD_CNT:  rdata_q <= upd_cnt_q;
                bp_pkg::REG_MISP_CNT: rdata_q <= misp_cnt_q;
                default:              rdata_q <= '0;
            endcase
        end
    end

    assign ctrl.enable = enable_q;

    assign s_axi_awready_o = !bvalid_q;
    assign s_axi_wready_o  = !bvalid_q;
    assign s_axi_bvalid_o  = bvalid_q;
    assign s_axi_bresp_o   = bp_pkg::RESP_OKAY;
    assign s_axi_arready_o = !rvalid_q;
    assign s_axi_rvalid_o  = rvalid_q;
    assign s_axi_rdata_o   = rdata_q;
    assign s_axi_rresp_o   = bp_pkg::RESP_OKAY;

endmodule

`default_nettype wire

// ==== hdl/bp_ctrl_if.sv ====
`default_nettype none

interface bp_ctrl_if;

    // Prediction enable from CTRL bit 0
    logic enable;

    // Current global history
    bp_pkg::ghr_t ghr;

    // Resolution events, one cycle wide
    logic upd_evt;
    logic misp_evt;

    // Register block side
    modport csr (output enable, input ghr, input upd_evt, input misp_evt);

    // Predictor side
    modport pht (input enable, output ghr, output upd_evt, output misp_evt);

endinterface

`default_nettype wire

// ==== hdl/bp_pkg.sv ====
`default_nettype none

package bp_pkg;

    // Table geometry
    localparam int IDX_W   = 8;
    localparam int ENTRIES = 256;
    localparam int GHR_W   = 8;

    // Instruction address, used for PC and branch target
    typedef logic [31:0] addr_t;

    // Global history, bit 0 holds the newest outcome
    typedef logic [GHR_W-1:0] ghr_t;

    // Index into the BTB and the PHT, from PC bits 9:2
    typedef logic [IDX_W-1:0] idx_t;

    // BTB tag, from PC bits 31:10
    typedef logic [31-IDX_W-2:0] tag_t;

    // 2-bit saturating counter, 0 strongly not-taken, 3 strongly taken
    typedef logic [1:0] ctr_t;
    localparam ctr_t CTR_INIT = 2'd1;

    // Wrapping event counter
    typedef logic [31:0] cnt_t;

    // Register byte offsets
    typedef logic [3:0] csr_addr_t;
    localparam csr_addr_t REG_CTRL     = 4'h0;
    localparam csr_addr_t REG_GHR      = 4'h4;
    localparam csr_addr_t REG_UPD_CNT  = 4'h8;
    localparam csr_addr_t REG_MISP_CNT = 4'hC;

    localparam logic [1:0] RESP_OKAY = 2'b00;

endpackage

`default_nettype wire

// ==== hdl/btb.sv ====
`default_nettype none

module btb (
    input  wire logic          clk_i,
    input  wire logic          rst_ni,
    input  wire bp_pkg::addr_t lk_pc_i,
    input  wire logic          upd_valid_i,
    input  wire logic          upd_taken_i,
    input  wire bp_pkg::addr_t upd_pc_i,
    input  wire bp_pkg::addr_t upd_target_i,

    output logic               hit_o,
    output bp_pkg::addr_t      target_o
);

    logic          valid_q  [bp_pkg::ENTRIES];
    bp_pkg::tag_t  tag_q    [bp_pkg::ENTRIES];
    bp_pkg::addr_t target_q [bp_pkg::ENTRIES];

    bp_pkg::idx_t  lk_idx;
    bp_pkg::tag_t  lk_tag;
    bp_pkg::idx_t  upd_idx;
    logic          wr_en;
    logic          lk_hit;
    logic          hit_q;
    bp_pkg::addr_t tgt_q;

    assign lk_idx  = lk_pc_i[bp_pkg::IDX_W+1:2];
    assign lk_tag  = lk_pc_i[31:bp_pkg::IDX_W+2];
    assign upd_idx = upd_pc_i[bp_pkg::IDX_W+1:2];

    // Only taken branches allocate
    assign wr_en  = upd_valid_i && upd_taken_i;
    assign lk_hit = valid_q[lk_idx] && (tag_q[lk_idx] == lk_tag);

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            for (int i = 0; i < bp_pkg::ENTRIES; i++) begin
                valid_q[i] <= 1'b0;
            end
        end else if (wr_en) begin
            valid_q[upd_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (wr_en) begin
            tag_q[upd_idx]    <= upd_pc_i[31:bp_pkg::IDX_W+2];
            target_q[upd_idx] <= upd_target_i;
        end
    end

    // Registered read, target forced to zero on a miss
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            hit_q <= 1'b0;
            tgt_q <= '0;
        end else begin
            hit_q <= lk_hit;
            tgt_q <= lk_hit ? target_q[lk_idx] : '0;
        end
    end

    assign hit_o    = hit_q;
    assign target_o = tgt_q;

endmodule

`default_nettype wire

// ==== hdl/gshare_bp_top.sv ====
`default_nettype none

module gshare_bp_top (
    input  wire logic              clk_i,
    input  wire logic              rst_ni,

    // Fetch side lookup
    input  wire logic              lk_valid_i,
    input  wire bp_pkg::addr_t     lk_pc_i,

    // Branch resolution
    input  wire logic              upd_valid_i,
    input  wire bp_pkg::addr_t     upd_pc_i,
    input  wire logic              upd_taken_i,
    input  wire bp_pkg::addr_t     upd_target_i,
    input  wire bp_pkg::ghr_t      upd_ghr_i,
    input  wire logic              upd_pred_taken_i,

    output logic                   lk_valid_o,
    output logic                   lk_hit_o,
    output logic                   lk_taken_o,
    output bp_pkg::addr_t          lk_target_o,
    output bp_pkg::ghr_t           lk_ghr_o,

    // AXI4-Lite register port
    input  wire logic              s_axi_awvalid_i,
    input  wire bp_pkg::csr_addr_t s_axi_awaddr_i,
    input  wire logic              s_axi_wvalid_i,
    input  wire logic [31:0]       s_axi_wdata_i,
    input  wire logic              s_axi_bready_i,
    input  wire logic              s_axi_arvalid_i,
    input  wire bp_pkg::csr_addr_t s_axi_araddr_i,
    input  wire logic              s_axi_rready_i,
    output logic                   s_axi_awready_o,
    output logic                   s_axi_wready_o,
    output logic                   s_axi_bvalid_o,
    output logic [1:0]             s_axi_bresp_o,
    output logic                   s_axi_arready_o,
    output logic                   s_axi_rvalid_o,
    output logic [31:0]            s_axi_rdata_o,
    output logic [1:0]             s_axi_rresp_o
);

    bp_ctrl_if ctrl_if ();

    logic lk_valid_q;
    logic btb_hit;
    logic pht_taken;

    btb u_btb (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .lk_pc_i      (lk_pc_i),
        .upd_valid_i  (upd_valid_i),
        .upd_taken_i  (upd_taken_i),
        .upd_pc_i     (upd_pc_i),
        .upd_target_i (upd_target_i),
        .hit_o        (btb_hit),
        .target_o     (lk_target_o)
    );

    pht u_pht (
        .clk_i            (clk_i),
        .rst_ni           (rst_ni),
        .lk_pc_i          (lk_pc_i),
        .upd_valid_i      (upd_valid_i),
        .upd_pc_i         (upd_pc_i),
        .upd_taken_i      (upd_taken_i),
        .upd_ghr_i        (upd_ghr_i),
        .upd_pred_taken_i (upd_pred_taken_i),
        .pred_taken_o     (pht_taken),
        .lk_ghr_o         (lk_ghr_o),
        .ctrl             (ctrl_if)
    );

    bp_csr u_csr (
        .clk_i           (clk_i),
        .rst_ni          (rst_ni),
        .s_axi_awvalid_i (s_axi_awvalid_i),
        .s_axi_awaddr_i  (s_axi_awaddr_i),
        .s_axi_wvalid_i  (s_axi_wvalid_i),
        .s_axi_wdata_i   (s_axi_wdata_i),
        .s_axi_bready_i  (s_axi_bready_i),
        .s_axi_arvalid_i (s_axi_arvalid_i),
        .s_axi_araddr_i  (s_axi_araddr_i),
        .s_axi_rready_i  (s_axi_rready_i),
        .s_axi_awready_o (s_axi_awready_o),
        .s_axi_wready_o  (s_axi_wready_o),
        .s_axi_bvalid_o  (s_axi_bvalid_o),
        .s_axi_bresp_o   (s_axi_bresp_o),
        .s_axi_arready_o (s_axi_arready_o),
        .s_axi_rvalid_o  (s_axi_rvalid_o),
        .s_axi_rdata_o   (s_axi_rdata_o),
        .s_axi_rresp_o   (s_axi_rresp_o),
        .ctrl            (ctrl_if)
    );

    // Lookup latency is one cycle, matching the table reads
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            lk_valid_q <= 1'b0;
        end else begin
            lk_valid_q <= lk_valid_i;
        end
    end

    assign lk_valid_o = lk_valid_q;
    assign lk_hit_o   = btb_hit;

    // Taken needs a target to redirect to
    assign lk_taken_o = ctrl_if.enable && btb_hit && pht_taken;

endmodule

`default_nettype wire

// ==== hdl/pht.sv ====
`default_nettype none

module pht (
    input  wire logic          clk_i,
    input  wire logic          rst_ni,
    input  wire bp_pkg::addr_t lk_pc_i,
    input  wire logic          upd_valid_i,
    input  wire bp_pkg::addr_t upd_pc_i,
    input  wire logic          upd_taken_i,
    input  wire bp_pkg::ghr_t  upd_ghr_i,
    input  wire logic          upd_pred_taken_i,

    output logic               pred_taken_o,
    output bp_pkg::ghr_t       lk_ghr_o,

    bp_ctrl_if.pht             ctrl
);

    bp_pkg::ctr_t ctr_q [bp_pkg::ENTRIES];
    bp_pkg::ghr_t ghr_q;
    bp_pkg::ghr_t lk_ghr_q;
    logic         pred_q;

    bp_pkg::idx_t lk_idx;
    bp_pkg::idx_t upd_idx;
    bp_pkg::ctr_t ctr_cur;
    bp_pkg::ctr_t ctr_next;

    // gshare index, PC bits XOR history
    assign lk_idx  = bp_pkg::idx_t'(lk_pc_i[bp_pkg::IDX_W+1:2]) ^ ghr_q;
    assign upd_idx = bp_pkg::idx_t'(upd_pc_i[bp_pkg::IDX_W+1:2]) ^ upd_ghr_i;
    assign ctr_cur = ctr_q[upd_idx];

    // Saturating step toward the resolved direction
    always_comb begin
        ctr_next = ctr_cur;
        if (upd_taken_i && !(&ctr_cur)) begin
            ctr_next = ctr_cur + 2'd1;
        end else if (!upd_taken_i && (|ctr_cur)) begin
            ctr_next = ctr_cur - 2'd1;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            for (int i = 0; i < bp_pkg::ENTRIES; i++) begin
                ctr_q[i] <= bp_pkg::CTR_INIT;
            end
        end else if (upd_valid_i) begin
            ctr_q[upd_idx] <= ctr_next;
        end
    end

    // History only moves at resolution
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            ghr_q <= '0;
        end else if (upd_valid_i) begin
            ghr_q <= {ghr_q[bp_pkg::GHR_W-2:0], upd_taken_i};
        end
    end

    // Lookup result sees the table and history from before any same-edge update
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            pred_q   <= 1'b0;
            lk_ghr_q <= '0;
        end else begin
            pred_q   <= ctr_q[lk_idx][1];
            lk_ghr_q <= ghr_q;
        end
    end

    assign pred_taken_o = pred_q;
    assign lk_ghr_o     = lk_ghr_q;

    assign ctrl.ghr      = ghr_q;
    assign ctrl.upd_evt  = upd_valid_i;
    assign ctrl.misp_evt = upd_valid_i && (upd_pred_taken_i != upd_taken_i);

endmodule

`default_nettype wire

// ==== src.f ====
+incdir+verif
hdl/bp_pkg.sv
hdl/bp_ctrl_if.sv
hdl/bp_csr.sv
hdl/pht.sv
hdl/btb.sv
hdl/gshare_bp_top.sv
verif/tb_gshare_bp.sv

// ==== verif/bp_model.svh ====
`ifndef BP_MODEL_SVH
`define BP_MODEL_SVH

// Reference state of the predictor
bp_pkg::ctr_t  m_ctr    [bp_pkg::ENTRIES];
logic          m_valid  [bp_pkg::ENTRIES];
bp_pkg::tag_t  m_tag    [bp_pkg::ENTRIES];
bp_pkg::addr_t m_target [bp_pkg::ENTRIES];
bp_pkg::ghr_t  m_ghr;
bp_pkg::cnt_t  m_upd_cnt;
bp_pkg::cnt_t  m_misp_cnt;
logic          m_enable;
logic [15:0]   lfsr_q;

function automatic void model_reset();
    for (int i = 0; i < bp_pkg::ENTRIES; i++) begin
        m_ctr[i]    = 2'd1;
        m_valid[i]  = 1'b0;
        m_tag[i]    = '0;
        m_target[i] = '0;
    end
    m_ghr      = '0;
    m_upd_cnt  = '0;
    m_misp_cnt = '0;
    m_enable   = 1'b1;
endfunction

// Prediction from the state before any update at the same edge
function automatic void model_lookup(input bp_pkg::addr_t pc, output logic hit,
                                     output logic taken, output bp_pkg::addr_t target);
    bp_pkg::idx_t slot;
    bp_pkg::idx_t hidx;
    slot   = pc[9:2];
    hidx   = pc[9:2] ^ m_ghr;
    hit    = m_valid[slot] && (m_tag[slot] == pc[31:10]);
    target = hit ? m_target[slot] : 32'd0;
    taken  = m_enable && hit && m_ctr[hidx][1];
endfunction

function automatic void model_update(bp_pkg::addr_t pc, logic taken, bp_pkg::addr_t target,
                                     bp_pkg::ghr_t ghr, logic pred);
    bp_pkg::idx_t hidx;
    hidx = pc[9:2] ^ ghr;
    if (taken && m_ctr[hidx] != 2'd3) begin
        m_ctr[hidx] = m_ctr[hidx] + 2'd1;
    end else if (!taken && m_ctr[hidx] != 2'd0) begin
        m_ctr[hidx] = m_ctr[hidx] - 2'd1;
    end
    if (taken) begin
        m_valid[pc[9:2]]  = 1'b1;
        m_tag[pc[9:2]]    = pc[31:10];
        m_target[pc[9:2]] = target;
    end
    m_ghr     = {m_ghr[6:0], taken};
    m_upd_cnt = m_upd_cnt + 1;
    if (pred != taken) begin
        m_misp_cnt = m_misp_cnt + 1;
    end
endfunction

// Galois LFSR, one step per bit drawn
function automatic logic [31:0] rand_bits(int n);
    logic [31:0] r;
    logic        b;
    r = '0;
    for (int i = 0; i < n; i++) begin
        b      = lfsr_q[0];
        lfsr_q = lfsr_q >> 1;
        if (b) begin
            lfsr_q = lfsr_q ^ 16'hB400;
        end
        r = {r[30:0], b};
    end
    return r;
endfunction

`endif

// ==== verif/tb_gshare_bp.sv ====
`default_nettype none

module tb_gshare_bp;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int TIMEOUT = 50;

    logic              clk_i = 1'b0;
    logic              rst_ni;
    logic              lk_valid_i;
    bp_pkg::addr_t     lk_pc_i;
    logic              upd_valid_i;
    bp_pkg::addr_t     upd_pc_i;
    logic              upd_taken_i;
    bp_pkg::addr_t     upd_target_i;
    bp_pkg::ghr_t      upd_ghr_i;
    logic              upd_pred_taken_i;
    logic              lk_valid_o;
    logic              lk_hit_o;
    logic              lk_taken_o;
    bp_pkg::addr_t     lk_target_o;
    bp_pkg::ghr_t      lk_ghr_o;
    logic              s_axi_awvalid_i;
    bp_pkg::csr_addr_t s_axi_awaddr_i;
    logic              s_axi_wvalid_i;
    logic [31:0]       s_axi_wdata_i;
    logic              s_axi_bready_i;
    logic              s_axi_arvalid_i;
    bp_pkg::csr_addr_t s_axi_araddr_i;
    logic              s_axi_rready_i;
    logic              s_axi_awready_o;
    logic              s_axi_wready_o;
    logic              s_axi_bvalid_o;
    logic [1:0]        s_axi_bresp_o;
    logic              s_axi_arready_o;
    logic              s_axi_rvalid_o;
    logic [31:0]       s_axi_rdata_o;
    logic [1:0]        s_axi_rresp_o;

    int                mismatch_errs = 0;
    int                other_errs = 0;
    bp_pkg::addr_t     pc_pool [8];
    logic [31:0]       rdata;
    logic [1:0]        resp;

    `include "bp_model.svh"

    gshare_bp_top dut_i (.*);

    always #2 clk_i = ~clk_i;

    task automatic check_bit(string name, logic exp, logic act);
        if (exp !== act) begin
            $display("MISMATCH %s: expected %0b actual %0b", name, exp, act);
            mismatch_errs++;
        end
    endtask

    task automatic check_addr(string name, bp_pkg::addr_t exp, bp_pkg::addr_t act);
        if (exp !== act) begin
            $display("MISMATCH %s: expected %h actual %h", name, exp, act);
            mismatch_errs++;
        end
    endtask

    task automatic check_ghr(string name, bp_pkg::ghr_t exp, bp_pkg::ghr_t act);
        if (exp !== act) begin
            $display("MISMATCH %s: expected %h actual %h", name, exp, act);
            mismatch_errs++;
        end
    endtask

    task automatic check_cnt(string name, bp_pkg::cnt_t exp, bp_pkg::cnt_t act);
        if (exp !== act) begin
            $display("MISMATCH %s: expected %0d actual %0d", name, exp, act);
            mismatch_errs++;
        end
    endtask

    task automatic check_resp(string name, logic [1:0] exp, logic [1:0] act);
        if (exp !== act) begin
            $display("MISMATCH %s: expected %b actual %b", name, exp, act);
            mismatch_errs++;
        end
    endtask

    // Called and returns at a falling edge
    task automatic axi_write(bp_pkg::csr_addr_t addr, logic [31:0] data);
        int t;
        s_axi_awvalid_i = 1'b1;
        s_axi_wvalid_i  = 1'b1;
        s_axi_awaddr_i  = addr;
        s_axi_wdata_i   = data;
        t = 0;
        while (!(s_axi_awready_o && s_axi_wready_o) && t < TIMEOUT) begin
            @(negedge clk_i);
            t++;
        end
        if (t >= TIMEOUT) begin
            $display("ERROR: write to offset %h was never accepted", addr);
            other_errs++;
        end
        @(negedge clk_i);
        s_axi_awvalid_i = 1'b0;
        s_axi_wvalid_i  = 1'b0;
        s_axi_bready_i  = 1'b1;
        t = 0;
        while (!s_axi_bvalid_o && t < TIMEOUT) begin
            @(negedge clk_i);
            t++;
        end
        if (t >= TIMEOUT) begin
            $display("ERROR: no write response for offset %h", addr);
            other_errs++;
        end
        check_resp("write resp", bp_pkg::RESP_OKAY, s_axi_bresp_o);
        @(negedge clk_i);
        s_axi_bready_i = 1'b0;
    endtask

    task automatic axi_read(bp_pkg::csr_addr_t addr, output logic [31:0] data,
                            output logic [1:0] rsp);
        int t;
        s_axi_arvalid_i = 1'b1;
        s_axi_araddr_i  = addr;
        t = 0;
        while (!s_axi_arready_o && t < TIMEOUT) begin
            @(negedge clk_i);
            t++;
        end
        if (t >= TIMEOUT) begin
            $display("ERROR: read of offset %h was never accepted", addr);
            other_errs++;
        end
        @(negedge clk_i);
        s_axi_arvalid_i = 1'b0;
        s_axi_rready_i  = 1'b1;
        t = 0;
        while (!s_axi_rvalid_o && t < TIMEOUT) begin
            @(negedge clk_i);
            t++;
        end
        if (t >= TIMEOUT) begin
            $display("ERROR: no read data for offset %h", addr);
            other_errs++;
        end
        data = s_axi_rdata_o;
        rsp  = s_axi_rresp_o;
        @(negedge clk_i);
        s_axi_rready_i = 1'b0;
    endtask

    // One cycle of lookup and update with the result checked at the next falling edge
    task automatic drive_cycle(string name, logic lv, bp_pkg::addr_t lpc, logic uv,
                               bp_pkg::addr_t upc, logic ut, bp_pkg::addr_t utgt,
                               bp_pkg::ghr_t ughr, logic up);
        logic          e_hit;
        logic          e_taken;
        bp_pkg::addr_t e_tgt;
        bp_pkg::ghr_t  e_ghr;
        lk_valid_i       = lv;
        lk_pc_i          = lpc;
        upd_valid_i      = uv;
        upd_pc_i         = upc;
        upd_taken_i      = ut;
        upd_target_i     = utgt;
        upd_ghr_i        = ughr;
        upd_pred_taken_i = up;
        model_lookup(lpc, e_hit, e_taken, e_tgt);
        e_ghr = m_ghr;
        if (uv) begin
            model_update(upc, ut, utgt, ughr, up);
        end
        @(posedge clk_i);
        @(negedge clk_i);
        lk_valid_i  = 1'b0;
        upd_valid_i = 1'b0;
        check_bit({name, " valid"}, lv, lk_valid_o);
        if (lv) begin
            check_bit({name, " hit"}, e_hit, lk_hit_o);
            check_bit({name, " taken"}, e_taken, lk_taken_o);
            check_addr({name, " target"}, e_tgt, lk_target_o);
            check_ghr({name, " ghr"}, e_ghr, lk_ghr_o);
        end
    endtask

    task automatic random_cycle();
        logic [2:0]    sel;
        logic          ut;
        bp_pkg::addr_t lpc;
        bp_pkg::ghr_t  ughr;
        sel = rand_bits(3);
        // Odd pool entries lean taken, even ones lean not-taken
        ut = sel[0] ? (rand_bits(2) != 0) : (rand_bits(2) == 0);
        if (rand_bits(1) != 0) begin
            lpc = pc_pool[rand_bits(3)];
        end else begin
            lpc = rand_bits(30) << 2;
        end
        ughr = (rand_bits(3) == 0) ? bp_pkg::ghr_t'(rand_bits(8)) : m_ghr;
        drive_cycle("random", rand_bits(2) != 0, lpc, rand_bits(2) != 0, pc_pool[sel], ut,
                    rand_bits(30) << 2, ughr, rand_bits(1) != 0);
    endtask

    initial begin
        lfsr_q           = 16'd36200;
        rst_ni           = 1'b0;
        lk_valid_i       = 1'b0;
        lk_pc_i          = '0;
        upd_valid_i      = 1'b0;
        upd_pc_i         = '0;
        upd_taken_i      = 1'b0;
        upd_target_i     = '0;
        upd_ghr_i        = '0;
        upd_pred_taken_i = 1'b0;
        s_axi_awvalid_i  = 1'b0;
        s_axi_awaddr_i   = '0;
        s_axi_wvalid_i   = 1'b0;
        s_axi_wdata_i    = '0;
        s_axi_bready_i   = 1'b0;
        s_axi_arvalid_i  = 1'b0;
        s_axi_araddr_i   = '0;
        s_axi_rready_i   = 1'b0;
        model_reset();
        // Second half of the pool aliases the first half's index with a new tag
        for (int i = 0; i < 4; i++) begin
            pc_pool[i]     = rand_bits(30) << 2;
            pc_pool[i + 4] = {bp_pkg::tag_t'(rand_bits(22)), pc_pool[i][9:2], 2'b00};
        end
        repeat (4) @(posedge clk_i);
        @(negedge clk_i);
        rst_ni = 1'b1;

        axi_read(bp_pkg::REG_CTRL, rdata, resp);
        check_resp("ctrl read resp", bp_pkg::RESP_OKAY, resp);
        check_bit("ctrl after reset", 1'b1, rdata[0]);
        axi_read(bp_pkg::REG_GHR, rdata, resp);
        check_resp("ghr read resp", bp_pkg::RESP_OKAY, resp);
        check_ghr("ghr after reset", '0, bp_pkg::ghr_t'(rdata));
        axi_read(bp_pkg::REG_UPD_CNT, rdata, resp);
        check_resp("upd cnt read resp", bp_pkg::RESP_OKAY, resp);
        check_cnt("upd cnt after reset", '0, rdata);
        axi_read(bp_pkg::REG_MISP_CNT, rdata, resp);
        check_resp("misp cnt read resp", bp_pkg::RESP_OKAY, resp);
        check_cnt("misp cnt after reset", '0, rdata);

        for (int i = 0; i < 16; i++) begin
            drive_cycle("cold", 1'b1, rand_bits(30) << 2, 1'b0, '0, 1'b0, '0, '0, 1'b0);
        end

        for (int i = 0; i < 2000; i++) begin
            random_cycle();
        end

        axi_read(bp_pkg::REG_GHR, rdata, resp);
        check_ghr("ghr after random", m_ghr, bp_pkg::ghr_t'(rdata));

        axi_read(bp_pkg::REG_UPD_CNT, rdata, resp);
        check_cnt("upd cnt", m_upd_cnt, rdata);
        axi_read(bp_pkg::REG_MISP_CNT, rdata, resp);
        check_cnt("misp cnt", m_misp_cnt, rdata);
        axi_write(bp_pkg::REG_UPD_CNT, 32'd0);
        m_upd_cnt = '0;
        axi_write(bp_pkg::REG_MISP_CNT, 32'd0);
        m_misp_cnt = '0;
        axi_read(bp_pkg::REG_UPD_CNT, rdata, resp);
        check_cnt("upd cnt cleared", '0, rdata);
        axi_read(bp_pkg::REG_MISP_CNT, rdata, resp);
        check_cnt("misp cnt cleared", '0, rdata);

        // Train every pool entry strongly taken under an all-ones history
        for (int i = 0; i < 8; i++) begin
            for (int j = 0; j < 4; j++) begin
                drive_cycle("train", 1'b1, pc_pool[i], 1'b1, pc_pool[i], 1'b1,
                            rand_bits(30) << 2, 8'hFF, 1'b1);
            end
        end

        // Disabled prediction keeps the BTB result but never predicts taken
        axi_write(bp_pkg::REG_CTRL, 32'd0);
        m_enable = 1'b0;
        for (int i = 0; i < 8; i++) begin
            drive_cycle("disabled", 1'b1, pc_pool[i], 1'b0, '0, 1'b0, '0, '0, 1'b0);
        end
        axi_write(bp_pkg::REG_CTRL, 32'd1);
        m_enable = 1'b1;
        for (int i = 0; i < 8; i++) begin
            drive_cycle("enabled", 1'b1, pc_pool[i], 1'b0, '0, 1'b0, '0, '0, 1'b0);
        end

        $display("Summary: %0d mismatches, %0d other errors", mismatch_errs, other_errs);
        if (mismatch_errs == 0 && other_errs == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire
